/* hw/dso_pkg.sv */
package dso_pkg;

  // record geometry
  localparam int REC_LEN  = 256;
  localparam int ADDR_W   = 8;
  localparam int PRE_LEN  = 128;
  localparam int POST_LEN = REC_LEN - PRE_LEN;  // trigger sample included
  localparam int SAMPLE_W = 8;

  // host bus
  localparam int WB_ADR_W = 10;
  localparam int WB_DAT_W = 32;

  // word addresses below the sample window (adr[9] = 0)
  typedef enum logic [WB_ADR_W-1:0] {
    REG_CTRL    = 10'd0,  // run, edge, level
    REG_STATUS  = 10'd1,  // ready, full, trig addr
    REG_RELEASE = 10'd2   // any write frees read bank
  } reg_addr_e;

  typedef enum logic [2:0] {
    CAP_IDLE,   // run off
    CAP_PRE,    // pre-trigger fill
    CAP_ARMED,  // waiting for trigger
    CAP_POST,   // post-trigger fill
    CAP_WAIT    // both banks occupied
  } cap_state_e;

endpackage

/* hw/dso_if.sv */
`timescale 1ns/100ps

interface buf_wr_if import dso_pkg::*; ();
  logic                wr_en;
  logic [ADDR_W-1:0]   wr_addr;
  logic [SAMPLE_W-1:0] wr_data;
  logic                trig_we;
  logic [ADDR_W-1:0]   trig_addr;
  logic                rec_done;   // last write of a record
  logic                full;

  modport ctrl (output wr_en, wr_addr, wr_data, trig_we, trig_addr, rec_done,
                input  full);
  modport mem  (input  wr_en, wr_addr, wr_data, trig_we, trig_addr, rec_done,
                output full);
endinterface

interface buf_rd_if import dso_pkg::*; ();
  logic [ADDR_W-1:0]   rd_addr;
  logic                release_bank;  // one-cycle pulse
  logic [SAMPLE_W-1:0] rd_data;
  logic                ready;
  logic                full;
  logic [ADDR_W-1:0]   rd_trig_addr;

  modport host (output rd_addr, release_bank,
                input  rd_data, ready, full, rd_trig_addr);
  modport mem  (input  rd_addr, release_bank,
                output rd_data, ready, full, rd_trig_addr);
endinterface

/* hw/trig_detect.sv */
`timescale 1ns/100ps

module trig_detect import dso_pkg::*; (
  input  logic                ad_clk,
  input  logic                rstn,
  input  logic                run,
  input  logic                edge_rise,
  input  logic [7:0]          level,
  input  logic [SAMPLE_W-1:0] sample_data,
  input  logic                sample_valid,
  output logic                trig_hit
);

  logic [SAMPLE_W-1:0] s1;  // previous accepted sample
  logic [SAMPLE_W-1:0] s2;  // the one before
  logic                rise_hit;
  logic                fall_hit;

  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) begin
      s1 <= '0;
      s2 <= '0;
    end else if (!run) begin
      s1 <= '0;
      s2 <= '0;
    end else if (sample_valid) begin
      s1 <= sample_data;
      s2 <= s1;
    end
  end

  // three-point crossing, the middle sample may sit on the level
  assign rise_hit = (s2 < level) && (s1 >= level) && (sample_data > level);
  assign fall_hit = (s2 > level) && (s1 <= level) && (sample_data < level);

  assign trig_hit = sample_valid && (edge_rise ? rise_hit : fall_hit);

endmodule

/* hw/wave_buffer.sv */
`timescale 1ns/100ps

module wave_buffer import dso_pkg::*; (
  input  logic ad_clk,
  input  logic rstn,
  input  logic run,
  buf_wr_if.mem wr,
  buf_rd_if.mem rd
);

  logic [SAMPLE_W-1:0] mem [2*REC_LEN];
  logic [SAMPLE_W-1:0] rd_data_q;
  logic [ADDR_W-1:0]   trig_addr_q [2];  // one per bank
  logic [1:0]          wr_ptr;           // bit 1 is the wrap bit
  logic [1:0]          rd_ptr;
  logic                ready;
  logic                full;

  assign ready = (wr_ptr != rd_ptr);
  assign full  = (wr_ptr[0] == rd_ptr[0]) && (wr_ptr[1] != rd_ptr[1]);

  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (!run) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr.rec_done)
        wr_ptr <= wr_ptr + 2'd1;  // flip write bank
      if (rd.release_bank && ready)
        rd_ptr <= rd_ptr + 2'd1;
    end
  end

  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) begin
      trig_addr_q[0] <= '0;
      trig_addr_q[1] <= '0;
    end else if (wr.trig_we) begin
      trig_addr_q[wr_ptr[0]] <= wr.trig_addr;
    end
  end

  // inferred dual-port RAM, bank bit on top
  always_ff @(posedge ad_clk) begin
    if (wr.wr_en)
      mem[{wr_ptr[0], wr.wr_addr}] <= wr.wr_data;
    rd_data_q <= mem[{rd_ptr[0], rd.rd_addr}];
  end

  assign wr.full         = full;
  assign rd.full         = full;
  assign rd.ready        = ready;
  assign rd.rd_data      = rd_data_q;
  assign rd.rd_trig_addr = trig_addr_q[rd_ptr[0]];

  // host may only hand back a bank that holds a record
  a_release_ready: assert property (
    @(posedge ad_clk) disable iff (!rstn)
    rd.release_bank |-> ready
  );

endmodule

/* hw/capture_ctrl.sv */
`timescale 1ns/100ps

module capture_ctrl import dso_pkg::*; (
  input  logic                ad_clk,
  input  logic                rstn,
  input  logic                run,
  input  logic [SAMPLE_W-1:0] sample_data,
  input  logic                sample_valid,
  input  logic                trig_hit,
  buf_wr_if.ctrl              wr
);

  cap_state_e        state;
  logic [ADDR_W-1:0] addr;      // wraps modulo REC_LEN
  logic [ADDR_W-1:0] post_cnt;  // post-trigger samples, trigger counted
  logic              active;
  logic              wr_go;
  logic              pre_last;
  logic              post_last;

  assign active    = (state == CAP_PRE) || (state == CAP_ARMED) || (state == CAP_POST);
  assign wr_go     = sample_valid && active && !wr.full;
  assign pre_last  = (addr == ADDR_W'(PRE_LEN - 1));
  assign post_last = (post_cnt == ADDR_W'(POST_LEN - 1));

  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) begin
      state    <= CAP_IDLE;
      addr     <= '0;
      post_cnt <= '0;
    end else if (!run) begin
      state    <= CAP_IDLE;
      addr     <= '0;
      post_cnt <= '0;
    end else begin
      case (state)
        CAP_IDLE: begin
          state <= CAP_PRE;
          addr  <= '0;
        end
        CAP_PRE: begin
          if (wr.full) begin
            state <= CAP_WAIT;  // just flipped into an occupied bank
          end else if (wr_go) begin
            addr <= addr + 1'b1;
            if (pre_last)
              state <= CAP_ARMED;
          end
        end
        CAP_ARMED: begin
          if (wr_go) begin
            addr <= addr + 1'b1;
            if (trig_hit) begin
              state    <= CAP_POST;
              post_cnt <= ADDR_W'(1);
            end
          end
        end
        CAP_POST: begin
          if (wr_go) begin
            if (post_last) begin
              state <= CAP_PRE;
              addr  <= '0;
            end else begin
              addr     <= addr + 1'b1;
              post_cnt <= post_cnt + 1'b1;
            end
          end
        end
        CAP_WAIT: begin
          if (!wr.full)
            state <= CAP_PRE;
        end
        default: state <= CAP_IDLE;
      endcase
    end
  end

  assign wr.wr_en     = wr_go;
  assign wr.wr_addr   = addr;
  assign wr.wr_data   = sample_data;
  assign wr.trig_we   = wr_go && (state == CAP_ARMED) && trig_hit;
  assign wr.trig_addr = addr;  // trigger sample's own address
  assign wr.rec_done  = wr_go && (state == CAP_POST) && post_last;

  // full only shows up between records, never mid-record
  a_full_between_records: assert property (
    @(posedge ad_clk) disable iff (!rstn)
    wr.full |-> (state != CAP_ARMED) && (state != CAP_POST)
  );

endmodule

/* hw/wb_dso_regs.sv */
`timescale 1ns/100ps

module wb_dso_regs import dso_pkg::*; (
  input  logic                ad_clk,
  input  logic                rstn,
  input  logic                wb_cyc,
  input  logic                wb_stb,
  input  logic                wb_we,
  input  logic [WB_ADR_W-1:0] wb_adr,
  input  logic [WB_DAT_W-1:0] wb_dat_i,
  input  logic [3:0]          wb_sel,
  output logic [WB_DAT_W-1:0] wb_dat_o,
  output logic                wb_ack,
  output logic                run,
  output logic                edge_rise,
  output logic [7:0]          level,
  buf_rd_if.host              rd
);

  logic                req;
  logic                win;       // sample window hit
  logic                win_q;
  logic [WB_DAT_W-1:0] reg_dat;
  logic [WB_DAT_W-1:0] reg_dat_q;
  logic                rel_q;
  reg_addr_e           reg_addr;

  assign req      = wb_cyc && wb_stb && !wb_ack;
  assign win      = wb_adr[9];
  assign reg_addr = reg_addr_e'(wb_adr);

  always_comb begin
    reg_dat = '0;
    case (reg_addr)
      REG_CTRL:   reg_dat = {16'd0, level, 6'd0, edge_rise, run};
      REG_STATUS: reg_dat = {16'd0, rd.rd_trig_addr, 6'd0, rd.full, rd.ready};
      default:    reg_dat = '0;  // release and holes read zero
    endcase
  end

  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) begin
      wb_ack    <= 1'b0;
      win_q     <= 1'b0;
      reg_dat_q <= '0;
      rel_q     <= 1'b0;
      run       <= 1'b0;
      edge_rise <= 1'b0;
      level     <= '0;
    end else begin
      wb_ack <= req;
      rel_q  <= 1'b0;
      if (req) begin
        win_q     <= win;
        reg_dat_q <= reg_dat;
        if (wb_we && !win) begin
          if (reg_addr == REG_CTRL) begin
            if (wb_sel[0]) begin
              run       <= wb_dat_i[0];
              edge_rise <= wb_dat_i[1];
            end
            if (wb_sel[1])
              level <= wb_dat_i[15:8];
          end
          if (reg_addr == REG_RELEASE)
            rel_q <= 1'b1;  // high during ack
        end
      end
    end
  end

  // RAM read finishes on the ack edge
  assign rd.rd_addr      = wb_adr[ADDR_W-1:0];
  assign rd.release_bank = rel_q;
  assign wb_dat_o        = win_q ? {{(WB_DAT_W-SAMPLE_W){1'b0}}, rd.rd_data} : reg_dat_q;

  // master keeps the strobe up through ack
  a_ack_in_cycle: assert property (
    @(posedge ad_clk) disable iff (!rstn)
    wb_ack |-> (wb_cyc && wb_stb)
  );

endmodule

/* hw/dso_capture_top.sv */
`timescale 1ns/100ps

module dso_capture_top import dso_pkg::*; (
  input  logic                ad_clk,
  input  logic                rstn,
  input  logic [SAMPLE_W-1:0] sample_data,
  input  logic                sample_valid,
  input  logic                wb_cyc,
  input  logic                wb_stb,
  input  logic                wb_we,
  input  logic [WB_ADR_W-1:0] wb_adr,
  input  logic [WB_DAT_W-1:0] wb_dat_i,
  input  logic [3:0]          wb_sel,
  output logic [WB_DAT_W-1:0] wb_dat_o,
  output logic                wb_ack
);

  logic       run;
  logic       edge_rise;
  logic [7:0] level;
  logic       trig_hit;

  buf_wr_if wr_bus ();
  buf_rd_if rd_bus ();

  trig_detect u_trig_detect (
    .ad_clk       (ad_clk),
    .rstn         (rstn),
    .run          (run),
    .edge_rise    (edge_rise),
    .level        (level),
    .sample_data  (sample_data),
    .sample_valid (sample_valid),
    .trig_hit     (trig_hit)
  );

  capture_ctrl u_capture_ctrl (
    .ad_clk       (ad_clk),
    .rstn         (rstn),
    .run          (run),
    .sample_data  (sample_data),
    .sample_valid (sample_valid),
    .trig_hit     (trig_hit),
    .wr           (wr_bus.ctrl)
  );

  wave_buffer u_wave_buffer (
    .ad_clk (ad_clk),
    .rstn   (rstn),
    .run    (run),
    .wr     (wr_bus.mem),
    .rd     (rd_bus.mem)
  );

  wb_dso_regs u_wb_dso_regs (
    .ad_clk    (ad_clk),
    .rstn      (rstn),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_i  (wb_dat_i),
    .wb_sel    (wb_sel),
    .wb_dat_o  (wb_dat_o),
    .wb_ack    (wb_ack),
    .run       (run),
    .edge_rise (edge_rise),
    .level     (level),
    .rd        (rd_bus.host)
  );

endmodule

/* test/tb_dso_tasks.svh */
task automatic idle_cycles(input int n);
  repeat (n) @(negedge ad_clk);
endtask

task automatic wb_write(input logic [WB_ADR_W-1:0] adr, input logic [WB_DAT_W-1:0] dat);
  @(negedge ad_clk);
  wb_cyc   = 1'b1;
  wb_stb   = 1'b1;
  wb_we    = 1'b1;
  wb_adr   = adr;
  wb_dat_i = dat;
  wb_sel   = 4'hf;
  @(negedge ad_clk);
  while (!wb_ack) @(negedge ad_clk);
  @(negedge ad_clk);  // stb held through the ack edge
  wb_cyc = 1'b0;
  wb_stb = 1'b0;
  wb_we  = 1'b0;
endtask

task automatic wb_read(input logic [WB_ADR_W-1:0] adr, output logic [WB_DAT_W-1:0] dat);
  @(negedge ad_clk);
  wb_cyc = 1'b1;
  wb_stb = 1'b1;
  wb_we  = 1'b0;
  wb_adr = adr;
  wb_sel = 4'hf;
  @(negedge ad_clk);
  while (!wb_ack) @(negedge ad_clk);
  dat = wb_dat_o;
  @(negedge ad_clk);
  wb_cyc = 1'b0;
  wb_stb = 1'b0;
endtask

// polls REG_STATUS until the given bit is set
task automatic wait_status(input int bit_pos, output bit seen, output logic [31:0] st);
  seen = 1'b0;
  st = '0;
  for (int i = 0; i < 100 && !seen; i++) begin
    wb_read(REG_STATUS, st);
    seen = st[bit_pos];
  end
endtask

task automatic start_capture(input bit rise, input logic [7:0] lvl);
  wb_write(REG_CTRL, 32'h0);  // run low clears banks and history
  offered.delete();
  rel_pos.delete();
  wb_write(REG_CTRL, {16'd0, lvl, 6'd0, rise, 1'b1});
  idle_cycles(3);
endtask

task automatic release_bank();
  wb_write(REG_RELEASE, 32'h0);
  rel_pos.push_back(offered.size());
  idle_cycles(4);
endtask

task automatic check_record(input int nth, input logic [7:0] lvl, input bit rise);
  check_nth   = nth;
  check_level = lvl;
  check_rise  = rise;
  check_go    = 1'b1;
  wait (!check_go);
endtask

task automatic offer_sample(input logic [7:0] v);
  int gap;
  gap = $random(seed) & 3;
  if (gap == 0) begin  // one idle cycle now and then
    @(negedge ad_clk);
    sample_valid = 1'b0;
  end
  @(negedge ad_clk);
  sample_data  = v;
  sample_valid = 1'b1;
  offered.push_back(v);
endtask

task automatic stream_triangle(input int lo, input int hi, input int step, input int count);
  int v;
  int dir;
  v = lo;
  dir = step;
  repeat (count) begin
    offer_sample(8'(v));
    if (v + dir > hi || v + dir < lo)
      dir = -dir;
    v = v + dir;
  end
  @(negedge ad_clk);
  sample_valid = 1'b0;
endtask

task automatic stream_ramp(input int step, input int count);
  int v;
  v = 0;
  repeat (count) begin
    offer_sample(8'(v));
    v = (v + step) % 256;  // sawtooth
  end
  @(negedge ad_clk);
  sample_valid = 1'b0;
endtask

/* test/tb_dso_capture.sv */
`timescale 1ns/100ps

module tb_dso_capture import dso_pkg::*; ();

  localparam int STIM_CYCLES = 10000;  // six tests, samples plus readback
  localparam int MAX_CYCLES  = 4 * STIM_CYCLES;

  logic                ad_clk;
  logic                rstn;
  logic [SAMPLE_W-1:0] sample_data;
  logic                sample_valid;
  logic                wb_cyc;
  logic                wb_stb;
  logic                wb_we;
  logic [WB_ADR_W-1:0] wb_adr;
  logic [WB_DAT_W-1:0] wb_dat_i;
  logic [3:0]          wb_sel;
  logic [WB_DAT_W-1:0] wb_dat_o;
  logic                wb_ack;

  logic [7:0] offered [$];  // every sample offered since run rose
  int         rel_pos [$];  // offered count at each release
  logic [7:0] exp_rec [REC_LEN];
  int         exp_trig;
  int         seed = 72299;
  int         cycles = 0;
  int         checks = 0;
  int         errors = 0;
  int         tests_run = 0;
  int         tests_failed = 0;
  int         test_err0;
  string      test_name;

  bit         check_go = 1'b0;  // handshake to the compare process
  int         check_nth;
  logic [7:0] check_level;
  bit         check_rise;

  dso_capture_top dut (
    .ad_clk       (ad_clk),
    .rstn         (rstn),
    .sample_data  (sample_data),
    .sample_valid (sample_valid),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_i     (wb_dat_i),
    .wb_sel       (wb_sel),
    .wb_dat_o     (wb_dat_o),
    .wb_ack       (wb_ack)
  );

  `include "tb_dso_tasks.svh"

  always #10 ad_clk = ~ad_clk;

  always @(posedge ad_clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("cycle limit of %0d reached before the tests finished", MAX_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  task automatic check_equal(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("Error: %s %s expected 0x%0h actual 0x%0h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_true(input bit cond, input string msg);
    checks++;
    assert (cond) else begin
      $display("%s: %s", test_name, msg);
      errors++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_err0 = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == test_err0) begin
      $display("test %s: pass", test_name);
    end else begin
      tests_failed++;
      $display("test %s: fail, %0d errors", test_name, errors - test_err0);
    end
  endtask

  // walks the offered samples with the trigger, write, drop and record rules
  function automatic bit predict_record(input int nth, input logic [7:0] lvl, input bit rise);
    logic [7:0] ram [REC_LEN];
    logic [7:0] s1;
    logic [7:0] s2;
    logic [7:0] cur;
    bit         hit;
    int         addr;
    int         post;
    int         state;  // 0 pre, 1 armed, 2 post
    int         trig;
    int         done;
    int         rel;
    int         ri;
    s1 = '0;
    s2 = '0;
    addr = 0;
    post = 0;
    state = 0;
    trig = 0;
    done = 0;
    rel = 0;
    ri = 0;
    foreach (ram[k])
      ram[k] = '0;
    for (int i = 0; i < offered.size(); i++) begin
      while (ri < rel_pos.size() && rel_pos[ri] <= i) begin
        rel++;
        ri++;
      end
      cur = offered[i];
      if (rise)
        hit = (s2 < lvl) && (s1 >= lvl) && (cur > lvl);
      else
        hit = (s2 > lvl) && (s1 <= lvl) && (cur < lvl);
      if (done - rel < 2) begin  // both banks taken means dropped
        ram[addr] = cur;
        if (state == 0) begin
          if (addr == PRE_LEN - 1)
            state = 1;
          addr = addr + 1;
        end else if (state == 1) begin
          if (hit) begin
            trig = addr;
            post = 1;
            state = 2;
          end
          addr = (addr + 1) % REC_LEN;
        end else if (post == REC_LEN - PRE_LEN - 1) begin
          if (done == nth) begin
            exp_trig = trig;
            for (int j = 0; j < REC_LEN; j++)
              exp_rec[j] = ram[(trig - PRE_LEN + j + REC_LEN) % REC_LEN];
            return 1'b1;
          end
          done++;
          state = 0;
          addr = 0;
        end else begin
          addr = (addr + 1) % REC_LEN;
          post++;
        end
      end
      s2 = s1;
      s1 = cur;
    end
    return 1'b0;
  endfunction

  always begin : compare_records
    logic [31:0] st;
    logic [31:0] rdat;
    logic [7:0]  idx;
    bit          found;
    bit          seen;
    wait (check_go);
    found = predict_record(check_nth, check_level, check_rise);
    check_true(found, "stimulus too short, the model finds no record");
    wait_status(0, seen, st);
    check_true(seen, "ready never rose");
    if (found && seen) begin
      check_equal("trigger address", 32'(exp_trig), {24'd0, st[15:8]});
      for (int j = 0; j < REC_LEN; j++) begin
        idx = 8'(exp_trig - PRE_LEN + j);  // record order, trigger at 128
        wb_read({2'b10, idx}, rdat);
        check_equal($sformatf("sample %0d", j), {24'd0, exp_rec[j]}, rdat);
      end
    end
    check_go = 1'b0;
  end

  initial begin
    logic [31:0] st;
    bit          seen;
    ad_clk = 1'b0;
    rstn = 1'b0;
    sample_data = '0;
    sample_valid = 1'b0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_i = '0;
    wb_sel = '0;
    repeat (8) @(posedge ad_clk);
    @(negedge ad_clk);
    rstn = 1'b1;

    begin_test("registers");
    wb_read(REG_STATUS, st);
    check_equal("status after reset", 32'h0, st);
    wb_write(REG_CTRL, 32'h5a03);
    wb_read(REG_CTRL, st);
    check_equal("control readback", 32'h5a03, st);
    wb_write(REG_CTRL, 32'h0);
    end_test();

    begin_test("rising_trigger");
    start_capture(1'b1, 8'd100);
    stream_triangle(20, 220, 5, 420);
    check_record(0, 8'd100, 1'b1);
    end_test();

    begin_test("falling_trigger");
    start_capture(1'b0, 8'd60);
    stream_triangle(0, 200, 4, 420);
    check_record(0, 8'd60, 1'b0);
    end_test();

    begin_test("no_crossing");
    start_capture(1'b1, 8'd100);
    stream_triangle(10, 90, 2, 1000);  // stays below the level
    wb_read(REG_STATUS, st);
    check_equal("ready and full", 32'h0, {30'd0, st[1:0]});
    end_test();

    begin_test("back_pressure");
    start_capture(1'b1, 8'd100);
    stream_triangle(20, 220, 5, 1100);  // later triggers land while full
    wait_status(1, seen, st);
    check_true(seen, "full never rose after two records");
    release_bank();
    check_record(1, 8'd100, 1'b1);
    stream_triangle(20, 220, 5, 420);
    wait_status(1, seen, st);
    check_true(seen, "third record never filled the freed bank");
    release_bank();
    check_record(2, 8'd100, 1'b1);
    end_test();

    begin_test("run_restart");
    stream_triangle(20, 220, 5, 420);  // fills the bank freed last
    wait_status(1, seen, st);
    check_true(seen, "full never rose before run was cleared");
    wb_write(REG_CTRL, 32'h6402);  // run off, banks still full
    wb_read(REG_STATUS, st);
    check_equal("ready and full after run off", 32'h0, {30'd0, st[1:0]});
    start_capture(1'b1, 8'd150);
    stream_ramp(3, 420);
    check_record(0, 8'd150, 1'b1);
    end_test();

    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    $finish;
  end

endmodule

/* verilog.f */
+incdir+test
hw/dso_pkg.sv
hw/dso_if.sv
hw/trig_detect.sv
hw/wave_buffer.sv
hw/capture_ctrl.sv
hw/wb_dso_regs.sv
hw/dso_capture_top.sv
test/tb_dso_capture.sv

/* Makefile */
SIM := obj_dir/Vtb_dso_capture
SRC := $(shell grep -v '^+' verilog.f) test/tb_dso_tasks.svh

.PHONY: all run clean

all: run

$(SIM): verilog.f $(SRC)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_dso_capture -f verilog.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
